// ==== Makefile ====
# Verilator flow for the perf counter block
# make sim builds, runs and checks the log, make clean removes the outputs

VERILATOR ?= verilator
TOP       ?= perfCounterTb
FILELIST  ?= verilog.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
PASSMSG   ?= All checks passed
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASSMSG)" $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== sim/perfCounterTb.sv ====
//////////////////////////////
// directed testbench for the perf counter block, CSR reads and writes plus event stimulus
// one line per test, then a summary line and the overall verdict
//////////////////////////////
`timescale 1ns/1ps

module perfCounterTb;
  import perfCounterPkg::*;

  localparam int NumCounters = 16;

  logic        clk;
  logic        reset;
  csrReq_t     req;
  pipeEvents_t ev;
  logic        stallE, stallM, flushM, loadStallD;
  logic [63:0] mtime;
  csrResp_t    resp;

  integer      seed;
  int          errCount;
  int          checkCount;
  int          testCount;
  logic [63:0] model [NumCounters]; // expected counts for counters 1 and up
  logic        modelE, modelM;      // load stall flops E and M

  perfCounterTop #(.NumCounters(NumCounters)) i_dut (
    .clk, .reset, .req, .ev, .stallE, .stallM, .flushM, .loadStallD, .mtime, .resp
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk; // 10 ns period
  end

  ////////////////////////////// helpers
  task automatic checkValue(input string name, input logic [31:0] exp, input logic [31:0] got);
    checkCount++;
    assert (got === exp) else begin
      $display("[FAIL] %s: expected %h, actual %h", name, exp, got);
      errCount++;
    end
  endtask

  task automatic idleEvents();
    ev         = '0;
    stallE     = 1'b0;
    stallM     = 1'b0;
    flushM     = 1'b0;
    loadStallD = 1'b0;
  endtask

  // drives at edge + 1, samples mid-cycle, returns at the next edge + 1
  task automatic csrRead(input logic [11:0] addr, input privMode_t priv,
                         output logic [31:0] data, output logic ill);
    req = '{wrEn: 1'b0, addr: addr, wdata: '0, priv: priv};
    #1;
    data = resp.rdata;
    ill  = resp.illegal;
    @(posedge clk);
    #1;
  endtask

  // single-cycle write strobe with the illegal flag the DUT gave it
  task automatic csrWrite(input logic [11:0] addr, input privMode_t priv,
                          input logic [31:0] wdata, output logic ill);
    req = '{wrEn: 1'b1, addr: addr, wdata: wdata, priv: priv};
    #1;
    ill = resp.illegal;
    @(posedge clk);
    #1;
    req.wrEn = 1'b0;
  endtask

  task automatic readCheck(input string name, input logic [11:0] addr, input privMode_t priv,
                           input logic [31:0] expData, input logic expIll);
    logic [31:0] data;
    logic        ill;
    csrRead(addr, priv, data, ill);
    checkValue({name, " rdata"}, expData, data);
    checkValue({name, " illegal"}, 32'(expIll), 32'(ill));
  endtask

  // polls a low half until it reaches target
  task automatic waitCount(input logic [11:0] addr, input logic [31:0] target,
                           input int maxPolls, output int polls);
    logic [31:0] data;
    logic        ill;
    polls = 0;
    data  = ~target;
    while (data !== target && polls < maxPolls) begin
      csrRead(addr, privMachine, data, ill);
      polls++;
    end
    if (data !== target) begin
      $display("timeout: counter at %h did not reach %h in %0d reads", addr, target, maxPolls);
      errCount++;
    end
  endtask

  // instrValid high for n cycles with other event bits as the caller left them
  task automatic pulseValid(input int n);
    ev.instrValid = 1'b1;
    repeat (n) @(posedge clk);
    #1;
    idleEvents();
  endtask

  task automatic endTest(input string name, input int errStart);
    testCount++;
    $display("%-14s %s, %0d errors", name, (errCount == errStart) ? "ok" : "bad",
             errCount - errStart);
  endtask

  ////////////////////////////// event model
  function automatic logic [NumCounters-1:0] eventIncrements(pipeEvents_t e, logic lsM);
    logic [NumCounters-1:0] inc;
    logic                   v;
    v       = e.instrValid;
    inc     = '0;
    inc[0]  = 1'b1;                 // cycle
    inc[2]  = v;
    inc[3]  = v & lsM;
    inc[4]  = v & e.bpDirWrong;
    inc[5]  = v & e.instrClass[0];
    inc[6]  = v & e.btbTargetWrong;
    inc[7]  = v & e.instrClass[1] & ~e.instrClass[2];
    inc[8]  = v & e.rasWrong;
    inc[9]  = v & e.instrClass[2];
    inc[10] = v & e.iclassWrong;
    inc[11] = v & e.dcacheAccess;
    inc[12] = e.dcacheMiss;         // misses ignore instrValid
    inc[13] = v & e.icacheAccess;
    inc[14] = e.icacheMiss;
    inc[15] = v & e.bpWrong;
    return inc;
  endfunction

  task automatic randomCycle();
    logic [NumCounters-1:0] inc;
    logic [31:0]            r;
    r          = $random(seed);
    ev         = pipeEvents_t'(r[13:0]);
    loadStallD = r[14];
    stallE     = (r[17:15] == 3'd0); // about one cycle in eight
    stallM     = (r[20:18] == 3'd0);
    flushM     = (r[23:21] == 3'd0);
    inc        = eventIncrements(ev, modelM);
    @(posedge clk);
    for (int i = 2; i < NumCounters; i++) begin
      model[i] += 64'(inc[i]);
    end
    if (!stallM) modelM = flushM ? 1'b0 : modelE; // M first so it takes the old E
    if (!stallE) modelE = loadStallD;
    #1;
  endtask

  ////////////////////////////// tests
  task automatic testReset();
    int errStart;
    errStart = errCount;
    for (int i = 2; i < NumCounters; i++) begin
      readCheck($sformatf("reset lo%0d", i), MhpmCounterBase + 12'(i), privMachine, 32'h0, 1'b0);
      readCheck($sformatf("reset hi%0d", i), MhpmCounterHBase + 12'(i), privMachine, 32'h0, 1'b0);
    end
    readCheck("reset inhibit", McountInhibitAdr, privMachine, 32'h0, 1'b0);
    readCheck("reset mcen", McounterEnAdr, privMachine, 32'h0, 1'b0);
    readCheck("reset scen", ScounterEnAdr, privMachine, 32'h0, 1'b0);
    endTest("resetValues", errStart);
  endtask

  task automatic testMcycle();
    int          errStart;
    int          polls;
    logic [31:0] v;
    logic        ill;
    errStart = errCount;
    v        = $random(seed) & 32'h0FFF_FFFF; // no wrap in the low half
    csrWrite(MhpmCounterBase, privMachine, v, ill);
    waitCount(MhpmCounterBase, v + 32'd6, 20, polls); // reads V, V+1 .. V+6
    checkValue("mcycle polls", 32'd7, 32'(polls));
    readCheck("mcycle next", MhpmCounterBase, privMachine, v + 32'd7, 1'b0);
    endTest("mcycle", errStart);
  endtask

  task automatic testRandomEvents();
    int errStart;
    errStart = errCount;
    repeat (200) randomCycle();
    idleEvents(); // counters 2 and up hold from here
    for (int i = 1; i < NumCounters; i++) begin
      readCheck($sformatf("events lo%0d", i), MhpmCounterBase + 12'(i), privMachine,
                model[i][31:0], 1'b0);
      readCheck($sformatf("events hi%0d", i), MhpmCounterHBase + 12'(i), privMachine,
                model[i][63:32], 1'b0);
    end
    endTest("randomEvents", errStart);
  endtask

  task automatic testCarry();
    int   errStart;
    logic ill;
    errStart = errCount;
    csrWrite(MhpmCounterHBase + 12'd11, privMachine, 32'h5, ill);
    readCheck("hi only", MhpmCounterHBase + 12'd11, privMachine, 32'h5, 1'b0);
    readCheck("lo kept", MhpmCounterBase + 12'd11, privMachine, model[11][31:0], 1'b0);
    csrWrite(MhpmCounterBase + 12'd11, privMachine, 32'hFFFF_FFFF, ill);
    ev.dcacheAccess = 1'b1;
    pulseValid(1); // one event that carries into hi
    model[2]  += 64'd1;
    model[11]  = {32'h6, 32'h0};
    readCheck("carry lo", MhpmCounterBase + 12'd11, privMachine, 32'h0, 1'b0);
    readCheck("carry hi", MhpmCounterHBase + 12'd11, privMachine, 32'h6, 1'b0);
    readCheck("alias lo", HpmCounterBase + 12'd11, privMachine, 32'h0, 1'b0);
    readCheck("alias hi", HpmCounterHBase + 12'd11, privMachine, 32'h6, 1'b0);
    endTest("carry", errStart);
  endtask

  task automatic testInhibit();
    int   errStart;
    logic ill;
    errStart = errCount;
    csrWrite(McountInhibitAdr, privMachine, 32'h6, ill);             // bit 1 is reserved
    readCheck("inhibit rsvd", McountInhibitAdr, privMachine, 32'h4, 1'b0);
    pulseValid(5);                                                   // minstret frozen
    readCheck("held", MhpmCounterBase + 12'd2, privMachine, model[2][31:0], 1'b0);
    csrWrite(McountInhibitAdr, privMachine, 32'h0, ill);
    pulseValid(3);
    model[2] += 64'd3;
    readCheck("resumed lo", MhpmCounterBase + 12'd2, privMachine, model[2][31:0], 1'b0);
    readCheck("resumed hi", MhpmCounterHBase + 12'd2, privMachine, model[2][63:32], 1'b0);
    endTest("inhibit", errStart);
  endtask

  task automatic testPrivilege();
    int   errStart;
    logic ill;
    errStart = errCount;
    mtime    = {$random(seed), $random(seed)};
    readCheck("S no cen", HpmCounterHBase + 12'd11, privSuper, 32'h0, 1'b1);
    readCheck("U none", HpmCounterHBase + 12'd11, privUser, 32'h0, 1'b1);
    readCheck("S mhpm", MhpmCounterHBase + 12'd11, privSuper, 32'h0, 1'b1);
    csrWrite(McounterEnAdr, privMachine, 32'h802, ill);   // time and counter 11
    readCheck("S cen", HpmCounterHBase + 12'd11, privSuper, 32'h6, 1'b0);
    readCheck("U cen only", HpmCounterHBase + 12'd11, privUser, 32'h0, 1'b1);
    csrWrite(ScounterEnAdr, privSuper, 32'h802, ill);
    checkValue("S scen write", 32'h0, 32'(ill));
    readCheck("S both", HpmCounterHBase + 12'd11, privSuper, 32'h6, 1'b0);
    readCheck("U both", HpmCounterHBase + 12'd11, privUser, 32'h6, 1'b0);
    readCheck("U time", TimeAdr, privUser, mtime[31:0], 1'b0);
    readCheck("M timeh", TimeHAdr, privMachine, mtime[63:32], 1'b0);
    csrWrite(McounterEnAdr, privSuper, 32'h0, ill);       // S cannot touch mcounteren
    checkValue("S mcen write", 32'h1, 32'(ill));
    readCheck("mcen kept", McounterEnAdr, privMachine, 32'h802, 1'b0);
    csrWrite(McounterEnAdr, privMachine, 32'h0, ill);
    readCheck("S scen only", HpmCounterHBase + 12'd11, privSuper, 32'h0, 1'b1);
    readCheck("U scen only", HpmCounterHBase + 12'd11, privUser, 32'h0, 1'b1);
    csrWrite(HpmCounterBase + 12'd11, privMachine, 32'h1234, ill);
    checkValue("alias write", 32'h1, 32'(ill));
    readCheck("alias dropped", MhpmCounterBase + 12'd11, privMachine, 32'h0, 1'b0);
    csrWrite(TimeAdr, privMachine, 32'h0, ill);
    checkValue("time write", 32'h1, 32'(ill));
    readCheck("no counter16", MhpmCounterBase + 12'd16, privMachine, 32'h0, 1'b1);
    readCheck("unmapped", 12'h7C0, privMachine, 32'h0, 1'b1);
    endTest("privilege", errStart);
  endtask

  ////////////////////////////// main sequence
  initial begin
    seed       = 69;
    errCount   = 0;
    checkCount = 0;
    testCount  = 0;
    modelE     = 1'b0;
    modelM     = 1'b0;
    for (int i = 0; i < NumCounters; i++) begin
      model[i] = '0;
    end
    reset = 1'b1;
    req   = '0;
    mtime = '0;
    idleEvents();
    repeat (8) @(posedge clk);
    #1;
    reset = 1'b0;

    testReset();
    testMcycle();
    testRandomEvents();
    testCarry();
    testInhibit();
    testPrivilege();

    $display("summary: %0d tests, %0d checks, %0d errors", testCount, checkCount, errCount);
    if (errCount == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// ==== sim/perfCounter_sva.sv ====
//////////////////////////////
// concurrent checks on the perf counter top level, attached with bind
//////////////////////////////
`timescale 1ns/1ps

module perfCounter_sva (
  input logic                                   clk,
  input logic                                   reset,
  input perfCounterPkg::csrReq_t                req,
  input perfCounterPkg::csrResp_t               resp,
  input logic [perfCounterPkg::MaxCounters-1:0] counterEn,
  input logic [63:0]                            minstret
);
  import perfCounterPkg::*;

  logic userAlias; // user read of a read-only alias, time included

  assign userAlias = (req.priv == privUser) && !req.wrEn &&
                     ((req.addr[11:5] == HpmCounterBase[11:5]) ||
                      (req.addr[11:5] == HpmCounterHBase[11:5]));

  ////////////////////////////// response rules
  illegalReadsZero: assert property (@(posedge clk) disable iff (reset)
    resp.illegal |-> (resp.rdata == '0))
    else $error("illegal access returned nonzero rdata");

  // M has to grant the counter before U can see it
  userNeedsCounterEn: assert property (@(posedge clk) disable iff (reset)
    (userAlias && !counterEn[req.addr[4:0]]) |-> resp.illegal)
    else $error("user read without mcounteren bit was accepted");

  ////////////////////////////// reset state
  minstretClearAfterReset: assert property (@(posedge clk)
    ($past(reset) && !reset) |-> (minstret == 64'd0))
    else $error("minstret not cleared by reset");

endmodule

bind perfCounterTop perfCounter_sva i_sva (
  .clk, .reset, .req, .resp, .counterEn,
  .minstret (counts[2].full)
);

// ==== verilog.f ====
verilog/perfCounterPkg.sv
verilog/counterEvents.sv
verilog/counterBank.sv
verilog/counterEnableRegs.sv
verilog/counterCsrControl.sv
verilog/perfCounterTop.sv
sim/perfCounter_sva.sv
sim/perfCounterTb.sv

// ==== verilog/counterBank.sv ====
//////////////////////////////
// bank of 64-bit counters, written a half at a time over the 32-bit CSR path
//////////////////////////////
`timescale 1ns/1ps

module counterBank #(
  parameter int NumCounters = 16
) (
  input  logic                         clk,
  input  logic                         reset,
  input  logic [NumCounters-1:0]       incEvent,
  input  logic [NumCounters-1:0]       inhibit,
  input  logic [NumCounters-1:0]       wrLo,    // one-hot low-half write
  input  logic [NumCounters-1:0]       wrHi,    // one-hot high-half write
  input  logic [perfCounterPkg::Xlen-1:0] wdata,
  output perfCounterPkg::counterWord_u counts [NumCounters]
);
  import perfCounterPkg::*;

  for (genvar i = 0; i < NumCounters; i++) begin : g_cnt
    if (i == 1) begin : g_none
      // slot 1 is reserved, time is read from mtime instead
      assign counts[i] = '0;
    end else begin : g_live
      counterWord_u cntQ;   // current count
      counterWord_u sum;    // count plus this cycle's event
      counterWord_u cntD;   // next count
      logic         bump;

      assign bump     = incEvent[i] & ~inhibit[i];
      assign sum.full = cntQ.full + 64'(bump); // carry crosses halves here

      ////////////////////////////// next state
      // a written half takes wdata, the other half keeps the sum and its carry
      always_comb begin
        cntD.halves.lo = wrLo[i] ? wdata : sum.halves.lo;
        cntD.halves.hi = wrHi[i] ? wdata : sum.halves.hi;
      end

      always_ff @(posedge clk) begin
        if (reset) cntQ <= '0;
        else cntQ <= cntD;
      end

      assign counts[i] = cntQ;
    end
  end

endmodule

// ==== verilog/counterCsrControl.sv ====
//////////////////////////////
// CSR decode for the counter block: privilege check, write strobes and read mux
// purely combinational, resp follows req in the same cycle
//////////////////////////////
`timescale 1ns/1ps

module counterCsrControl #(
  parameter int NumCounters = 16
) (
  input  perfCounterPkg::csrReq_t                req,
  input  perfCounterPkg::counterWord_u           counts [NumCounters],
  input  logic [perfCounterPkg::MaxCounters-1:0] counterEn,
  input  logic [perfCounterPkg::MaxCounters-1:0] scounterEn,
  input  logic [perfCounterPkg::MaxCounters-1:0] inhibitVal,
  input  logic [63:0]                            mtime,
  output logic [NumCounters-1:0]                 wrLo,
  output logic [NumCounters-1:0]                 wrHi,
  output logic                                   wrInhibit,
  output logic                                   wrCounterEn,
  output logic                                   wrScounterEn,
  output perfCounterPkg::csrResp_t               resp
);
  import perfCounterPkg::*;

  logic [4:0]      idx;          // counter number from addr bits 4:0
  logic            inMLo, inMHi; // machine counter ranges
  logic            inULo, inUHi; // read-only aliases, time included
  logic            inTime, inTimeH;
  logic            isInhibit, isCen, isScen;
  logic            isMachine, isSuper, isUser;
  logic            aliasOk;      // lower-mode alias read allowed
  logic            legal;
  logic            wrOk;
  counterWord_u    selWord;
  logic [Xlen-1:0] readVal;

  // base is 32-aligned, so the top 7 bits pick the range
  function automatic logic inRange(logic [11:0] adr, logic [11:0] base);
    return (adr[11:5] == base[11:5]) && (int'(adr[4:0]) < NumCounters);
  endfunction

  ////////////////////////////// address decode
  assign idx       = req.addr[4:0];
  assign inMLo     = inRange(req.addr, MhpmCounterBase);
  assign inMHi     = inRange(req.addr, MhpmCounterHBase);
  assign inULo     = inRange(req.addr, HpmCounterBase);
  assign inUHi     = inRange(req.addr, HpmCounterHBase);
  assign inTime    = (req.addr == TimeAdr);   // sits inside the low alias range
  assign inTimeH   = (req.addr == TimeHAdr);
  assign isInhibit = (req.addr == McountInhibitAdr);
  assign isCen     = (req.addr == McounterEnAdr);
  assign isScen    = (req.addr == ScounterEnAdr);

  assign isMachine = (req.priv == privMachine);
  assign isSuper   = (req.priv == privSuper);
  assign isUser    = (req.priv == privUser);

  // S needs mcounteren, U needs both enables
  assign aliasOk = isMachine |
                   (counterEn[idx] & (isSuper | (isUser & scounterEn[idx])));

  ////////////////////////////// access rules
  always_comb begin
    legal = 1'b0;                                        // unknown address
    if (inMLo | inMHi) legal = isMachine;
    else if (inULo | inUHi) legal = aliasOk & ~req.wrEn; // aliases never take writes
    else if (isInhibit | isCen) legal = isMachine;
    else if (isScen) legal = isMachine | isSuper;
  end

  assign wrOk = req.wrEn & legal;

  // one strobe per counter half, only the addressed one fires
  for (genvar i = 0; i < NumCounters; i++) begin : g_wr
    assign wrLo[i] = wrOk & inMLo & (idx == 5'(i));
    assign wrHi[i] = wrOk & inMHi & (idx == 5'(i));
  end

  assign wrInhibit    = wrOk & isInhibit;
  assign wrCounterEn  = wrOk & isCen;
  assign wrScounterEn = wrOk & isScen;

  ////////////////////////////// read mux
  // loop select keeps idx past NumCounters from indexing off the array
  always_comb begin
    selWord = '0;
    for (int i = 0; i < NumCounters; i++) begin
      if (idx == 5'(i)) selWord = counts[i];
    end
  end

  always_comb begin
    readVal = '0;                                   // illegal reads return 0
    if (legal) begin
      if (inTime) readVal = mtime[31:0];
      else if (inTimeH) readVal = mtime[63:32];
      else if (inMLo | inULo) readVal = selWord.halves.lo;
      else if (inMHi | inUHi) readVal = selWord.halves.hi;
      else if (isInhibit) readVal = inhibitVal;
      else if (isCen) readVal = counterEn;
      else if (isScen) readVal = scounterEn;
    end
  end

  assign resp = '{rdata: readVal, illegal: ~legal};

endmodule

// ==== verilog/counterEnableRegs.sv ====
//////////////////////////////
// mcountinhibit, mcounteren and scounteren, each with its own write strobe
//////////////////////////////
`timescale 1ns/1ps

module counterEnableRegs (
  input  logic                                   clk,
  input  logic                                   reset,
  input  logic                                   wrInhibit,
  input  logic                                   wrCounterEn,
  input  logic                                   wrScounterEn,
  input  logic [perfCounterPkg::Xlen-1:0]        wdata,
  output logic [perfCounterPkg::MaxCounters-1:0] inhibit,
  output logic [perfCounterPkg::MaxCounters-1:0] counterEn,
  output logic [perfCounterPkg::MaxCounters-1:0] scounterEn
);
  import perfCounterPkg::*;

  // bit 1 of mcountinhibit is reserved and reads 0
  localparam logic [MaxCounters-1:0] InhibitRsvd = MaxCounters'(2);

  logic [MaxCounters-1:0] wval;

  assign wval = wdata[MaxCounters-1:0];

  always_ff @(posedge clk) begin
    if (reset) begin
      inhibit    <= '0; // all counters run out of reset
      counterEn  <= '0; // no lower-mode access until M grants it
      scounterEn <= '0;
    end else begin
      if (wrInhibit) inhibit <= wval & ~InhibitRsvd;
      if (wrCounterEn) counterEn <= wval;
      if (wrScounterEn) scounterEn <= wval;
    end
  end

endmodule

// ==== verilog/counterEvents.sv ====
//////////////////////////////
// turns M-stage pipeline events into one increment bit per counter
//////////////////////////////
`timescale 1ns/1ps

module counterEvents #(
  parameter int NumCounters = 16
) (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        stallE,
  input  logic                        stallM,
  input  logic                        flushM,
  input  logic                        loadStallD,
  input  perfCounterPkg::pipeEvents_t ev,
  output logic [NumCounters-1:0]      incEvent
);
  import perfCounterPkg::*;

  logic                   loadStallE, loadStallM;
  logic                   valid;
  logic [MaxCounters-1:0] evAll; // full-width map, trimmed to NumCounters below

  ////////////////////////////// load stall pipe D -> E -> M
  // E stage is never flushed, the stall itself must survive
  always_ff @(posedge clk) begin
    if (reset) loadStallE <= 1'b0;
    else if (!stallE) loadStallE <= loadStallD;
  end

  // flush clears M only on a cycle where M advances
  always_ff @(posedge clk) begin
    if (reset) begin
      loadStallM <= 1'b0;
    end else if (!stallM) begin
      loadStallM <= flushM ? 1'b0 : loadStallE;
    end
  end

  assign valid = ev.instrValid;

  ////////////////////////////// event map
  always_comb begin
    evAll              = '0;                  // unmapped counters stay idle
    evAll[EvCycle]     = 1'b1;                // mcycle
    evAll[1]           = 1'b0;                // counter 1 does not exist
    evAll[EvInstret]   = valid;               // minstret
    evAll[EvLoadStall] = loadStallM & valid;
    evAll[EvBpDir]     = ev.bpDirWrong & valid;
    evAll[EvBranch]    = ev.instrClass[0] & valid;
    evAll[EvBtb]       = ev.btbTargetWrong & valid;
    // jump but not a return
    evAll[EvJump]      = ev.instrClass[1] & ~ev.instrClass[2] & valid;
    evAll[EvRas]       = ev.rasWrong & valid;
    evAll[EvReturn]    = ev.instrClass[2] & valid;
    evAll[EvIclass]    = ev.iclassWrong & valid;
    evAll[EvDcAccess]  = ev.dcacheAccess & valid;
    evAll[EvDcMiss]    = ev.dcacheMiss;           // miss pulses are not tied to retire
    evAll[EvIcAccess]  = ev.icacheAccess & valid;
    evAll[EvIcMiss]    = ev.icacheMiss;
    evAll[EvBpWrong]   = ev.bpWrong & valid;
  end

  assign incEvent = evAll[NumCounters-1:0];

endmodule

// ==== verilog/perfCounterPkg.sv ====
//////////////////////////////
// shared types, CSR addresses and event indices for the perf counter block
// each module imports this inside its body, ports use scoped names
//////////////////////////////
package perfCounterPkg;

  ////////////////////////////// widths
  localparam int Xlen        = 32; // RV32 hart only
  localparam int MaxCounters = 32; // width of the enable register fields

  // privilege levels, RISC-V encoding
  typedef enum logic [1:0] {
    privUser    = 2'b00,
    privSuper   = 2'b01,
    privMachine = 2'b11
  } privMode_t;

  typedef struct packed {
    logic            wrEn;  // final write value is valid this cycle
    logic [11:0]     addr;
    logic [Xlen-1:0] wdata;
    privMode_t       priv;
  } csrReq_t;

  // M-stage event levels from the pipeline
  typedef struct packed {
    logic       instrValid;     // valid and not flushed
    logic       bpDirWrong;
    logic       btbTargetWrong;
    logic       rasWrong;
    logic       iclassWrong;
    logic       bpWrong;
    logic [3:0] instrClass;     // bit 0 branch, bit 1 jump, bit 2 return
    logic       dcacheAccess;
    logic       dcacheMiss;     // one cycle at start of the miss
    logic       icacheAccess;
    logic       icacheMiss;
  } pipeEvents_t;

  typedef struct packed {
    logic [Xlen-1:0] hi;
    logic [Xlen-1:0] lo;
  } counterHalves_t;

  // same 64 bits, seen whole for the increment or as two CSR halves
  typedef union packed {
    logic [63:0]    full;
    counterHalves_t halves;
  } counterWord_u;

  typedef struct packed {
    logic [Xlen-1:0] rdata;
    logic            illegal;
  } csrResp_t;

  ////////////////////////////// CSR addresses
  localparam logic [11:0] MhpmCounterBase  = 12'hB00;
  localparam logic [11:0] MhpmCounterHBase = 12'hB80;
  localparam logic [11:0] HpmCounterBase   = 12'hC00; // user read-only aliases
  localparam logic [11:0] HpmCounterHBase  = 12'hC80;
  localparam logic [11:0] TimeAdr          = 12'hC01; // shadows CLINT mtime
  localparam logic [11:0] TimeHAdr         = 12'hC81;
  localparam logic [11:0] McountInhibitAdr = 12'h320;
  localparam logic [11:0] McounterEnAdr    = 12'h306;
  localparam logic [11:0] ScounterEnAdr    = 12'h106;

  ////////////////////////////// fixed event map
  localparam int EvCycle     = 0;
  localparam int EvInstret   = 2;
  localparam int EvLoadStall = 3;
  localparam int EvBpDir     = 4;
  localparam int EvBranch    = 5;
  localparam int EvBtb       = 6;
  localparam int EvJump      = 7;
  localparam int EvRas       = 8;
  localparam int EvReturn    = 9;
  localparam int EvIclass    = 10;
  localparam int EvDcAccess  = 11;
  localparam int EvDcMiss    = 12;
  localparam int EvIcAccess  = 13;
  localparam int EvIcMiss    = 14;
  localparam int EvBpWrong   = 15;

endpackage

// ==== verilog/perfCounterTop.sv ====
//////////////////////////////
// performance counter block top, CSR control plus event, counter and enable datapath
//////////////////////////////
`timescale 1ns/1ps

module perfCounterTop #(
  parameter int NumCounters = 16 // 3 to 32
) (
  input  logic                        clk,
  input  logic                        reset,
  input  perfCounterPkg::csrReq_t     req,
  input  perfCounterPkg::pipeEvents_t ev,
  input  logic                        stallE,
  input  logic                        stallM,
  input  logic                        flushM,
  input  logic                        loadStallD,
  input  logic [63:0]                 mtime,  // from CLINT
  output perfCounterPkg::csrResp_t    resp
);
  import perfCounterPkg::*;

  logic [NumCounters-1:0] incEvent;
  logic [NumCounters-1:0] wrLo, wrHi;
  logic [MaxCounters-1:0] inhibit, counterEn, scounterEn;
  logic                   wrInhibit, wrCounterEn, wrScounterEn;
  counterWord_u           counts [NumCounters];

  counterEvents #(.NumCounters(NumCounters)) i_events (
    .clk, .reset,
    .stallE, .stallM, .flushM,
    .loadStallD,
    .ev,
    .incEvent
  );

  counterBank #(.NumCounters(NumCounters)) i_bank (
    .clk, .reset,
    .incEvent,
    .inhibit (inhibit[NumCounters-1:0]),
    .wrLo, .wrHi,
    .wdata   (req.wdata),
    .counts
  );

  counterEnableRegs i_enRegs (
    .clk, .reset,
    .wrInhibit, .wrCounterEn, .wrScounterEn,
    .wdata   (req.wdata),
    .inhibit, .counterEn, .scounterEn
  );

  counterCsrControl #(.NumCounters(NumCounters)) i_ctrl (
    .req,
    .counts,
    .counterEn, .scounterEn,
    .inhibitVal (inhibit),
    .mtime,
    .wrLo, .wrHi,
    .wrInhibit, .wrCounterEn, .wrScounterEn,
    .resp
  );

endmodule
